/* src/stfwd_config.svh */
// ----------------------------------------------------------
// store-to-load forwarding configuration values
// widths, buffer depth, reset mask and register map
// ----------------------------------------------------------
`ifndef STFWD_CONFIG_SVH
`define STFWD_CONFIG_SVH

// data and address width
`define STFWD_XLEN 32

// store buffer slots, also the number of l0 entries
`define STFWD_SB_DEPTH 8
// log2 of the depth, width of slot and cache index
`define STFWD_IDX_W 3
// address bits above the cache index
`define STFWD_TAG_W 29

// addresses below 0x100 are reserved and never forwarded
`define STFWD_MASK_RST 32'hFFFF_FF00

// register map
`define STFWD_REG_CTRL 2'd0
`define STFWD_REG_MASK 2'd1
`define STFWD_REG_HITS 2'd2

`endif

/* src/stfwd_pkg.sv */
// ----------------------------------------------------------
// shared types of the store-to-load forwarding subsystem
// ----------------------------------------------------------
`include "stfwd_config.svh"

package stfwd_pkg;

  // ----------------------------------------------------------
  // access width
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    LS_BYTE = 2'b00,
    LS_HALF = 2'b01,
    LS_WORD = 2'b10
  } ldst_width_t;

  // ----------------------------------------------------------
  // address word
  // ----------------------------------------------------------
  // tag above, cache index in the low bits
  typedef struct packed {
    logic [`STFWD_TAG_W-1:0] tag;
    logic [`STFWD_IDX_W-1:0] idx;
  } fwd_addr_split_t;

  // same word, raw or split into tag and index
  typedef union packed {
    logic [`STFWD_XLEN-1:0] raw;
    fwd_addr_split_t        split;
  } fwd_addr_u;

  // ----------------------------------------------------------
  // requests and buffer contents
  // ----------------------------------------------------------
  // pushed store
  typedef struct packed {
    fwd_addr_u              addr;
    ldst_width_t            width;
    logic [`STFWD_XLEN-1:0] value;
  } st_req_t;

  // load lookup
  typedef struct packed {
    logic        valid;
    fwd_addr_u   addr;
    ldst_width_t width;
  } ld_req_t;

  // one store buffer slot, also the drain output
  typedef struct packed {
    logic                   valid;
    fwd_addr_u              addr;
    ldst_width_t            width;
    logic [`STFWD_XLEN-1:0] value;
  } sb_entry_t;

  // steering from the config block
  typedef struct packed {
    logic                   enable;
    logic [`STFWD_XLEN-1:0] mask;
  } fwd_cfg_t;

endpackage

/* src/fwd_cfg_regs.sv */
// ----------------------------------------------------------
// forwarding config registers
// enable bit, address mask and saturating forward-hit counter
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "stfwd_config.svh"

module fwd_cfg_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cfg_we_i,
  input  logic [1:0]             cfg_addr_i,
  input  logic [`STFWD_XLEN-1:0] cfg_wdata_i,
  output logic [`STFWD_XLEN-1:0] cfg_rdata_o,
  input  logic                   fwd_hit_i,
  output stfwd_pkg::fwd_cfg_t    fwd_cfg_o
);

  logic                   enable_q;
  logic [`STFWD_XLEN-1:0] mask_q;
  logic [`STFWD_XLEN-1:0] hits_q;

  // ----------------------------------------------------------
  // register writes
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b1;
      mask_q   <= `STFWD_MASK_RST;
      hits_q   <= '0;
    end else begin
      if (cfg_we_i && (cfg_addr_i == `STFWD_REG_CTRL)) begin
        enable_q <= cfg_wdata_i[0];
      end
      if (cfg_we_i && (cfg_addr_i == `STFWD_REG_MASK)) begin
        mask_q <= cfg_wdata_i;
      end
      // write to the counter clears it, wins over a hit
      if (cfg_we_i && (cfg_addr_i == `STFWD_REG_HITS)) begin
        hits_q <= '0;
      end else if (fwd_hit_i && (hits_q != '1)) begin
        // saturate at all ones
        hits_q <= hits_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // readback, combinational
  // ----------------------------------------------------------
  always_comb begin
    case (cfg_addr_i)
      `STFWD_REG_CTRL: cfg_rdata_o = {{(`STFWD_XLEN-1){1'b0}}, enable_q};
      `STFWD_REG_MASK: cfg_rdata_o = mask_q;
      `STFWD_REG_HITS: cfg_rdata_o = hits_q;
      default:         cfg_rdata_o = '0;
    endcase
  end

  // steering to the l0 cache
  assign fwd_cfg_o.enable = enable_q;
  assign fwd_cfg_o.mask   = mask_q;

endmodule

/* src/store_buffer.sv */
// ----------------------------------------------------------
// speculative store buffer
// circular queue with push, drain, flush and indexed readout
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "stfwd_config.svh"

module store_buffer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  // store side
  input  logic                    push_i,
  input  stfwd_pkg::st_req_t      st_req_i,
  output logic                    push_ok_o,
  output logic [`STFWD_IDX_W-1:0] tail_idx_o,
  output logic                    full_o,
  // drain side
  input  logic                    pop_i,
  output stfwd_pkg::sb_entry_t    drain_o,
  // readout for the forwarding cache
  input  logic [`STFWD_IDX_W-1:0] rd_idx_i,
  output stfwd_pkg::sb_entry_t    rd_entry_o
);

  import stfwd_pkg::*;

  // ----------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------
  // store payload per slot
  st_req_t                    slot_data_q [0:`STFWD_SB_DEPTH-1];
  // one valid bit per slot
  logic [`STFWD_SB_DEPTH-1:0] slot_valid_q;

  logic [`STFWD_IDX_W-1:0]    head_q;
  logic [`STFWD_IDX_W-1:0]    tail_q;
  // one bit wider than the index so full fits
  logic [`STFWD_IDX_W:0]      count_q;

  logic                       empty;
  logic                       push_ok;
  logic                       pop_ok;

  assign full_o  = (count_q == (`STFWD_IDX_W+1)'(`STFWD_SB_DEPTH));
  assign empty   = (count_q == '0);

  // flush discards a push or pop in the same cycle
  assign push_ok = push_i & ~full_o & ~flush_i;
  assign pop_ok  = pop_i & ~empty & ~flush_i;

  // ----------------------------------------------------------
  // payload write on an accepted push
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      slot_data_q[tail_q] <= st_req_i;
    end
  end

  // ----------------------------------------------------------
  // valid bits
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_valid_q <= '0;
    end else if (flush_i) begin
      slot_valid_q <= '0;
    end else begin
      // head and tail differ whenever both fire
      if (pop_ok) begin
        slot_valid_q[head_q] <= 1'b0;
      end
      if (push_ok) begin
        slot_valid_q[tail_q] <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------
  // index width is log2 of depth, so pointers wrap by themselves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop_ok) begin
        head_q <= head_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign push_ok_o  = push_ok;
  // slot that the current push lands in
  assign tail_idx_o = tail_q;

  // oldest entry with its valid bit
  assign drain_o.valid = slot_valid_q[head_q];
  assign drain_o.addr  = slot_data_q[head_q].addr;
  assign drain_o.width = slot_data_q[head_q].width;
  assign drain_o.value = slot_data_q[head_q].value;

  // slot asked for by the l0 cache
  assign rd_entry_o.valid = slot_valid_q[rd_idx_i];
  assign rd_entry_o.addr  = slot_data_q[rd_idx_i].addr;
  assign rd_entry_o.width = slot_data_q[rd_idx_i].width;
  assign rd_entry_o.value = slot_data_q[rd_idx_i].value;

  // ----------------------------------------------------------
  // assertions
  // ----------------------------------------------------------
  // occupancy stays within the slot count
  a_count_max : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    count_q <= (`STFWD_IDX_W+1)'(`STFWD_SB_DEPTH)
  ) else $error("store buffer occupancy above depth");

  // the drain side never pops an empty buffer
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (pop_i && !flush_i) |-> !empty
  ) else $error("pop while store buffer empty");

endmodule

/* src/l0_fwd_cache.sv */
// ----------------------------------------------------------
// level-zero forwarding cache
// maps address index to the slot of the latest store
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "stfwd_config.svh"

module l0_fwd_cache (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  stfwd_pkg::fwd_cfg_t     fwd_cfg_i,
  // store side, same edge as the buffer write
  input  logic                    push_ok_i,
  input  stfwd_pkg::st_req_t      st_req_i,
  input  logic [`STFWD_IDX_W-1:0] tail_idx_i,
  // load lookup
  input  stfwd_pkg::ld_req_t      ld_req_i,
  output logic [`STFWD_IDX_W-1:0] sb_idx_o,
  input  stfwd_pkg::sb_entry_t    sb_entry_i,
  output logic                    fwd_valid_o,
  output logic [`STFWD_XLEN-1:0]  fwd_value_o,
  output logic                    fwd_hit_o
);

  // ----------------------------------------------------------
  // cache entries
  // ----------------------------------------------------------
  // tag and store buffer slot per index
  typedef struct packed {
    logic [`STFWD_TAG_W-1:0] tag;
    logic [`STFWD_IDX_W-1:0] slot;
  } l0_line_t;

  l0_line_t                   line_q [0:`STFWD_SB_DEPTH-1];
  logic [`STFWD_SB_DEPTH-1:0] line_valid_q;

  logic                       st_cached;
  logic [`STFWD_IDX_W-1:0]    ld_idx;
  logic                       cache_hit;
  logic                       st_hit;
  logic                       fwd_valid;

  // only stores with an address bit inside the mask are recorded
  assign st_cached = push_ok_i &
                     ((st_req_i.addr.raw & fwd_cfg_i.mask) != '0);

  // ----------------------------------------------------------
  // update
  // ----------------------------------------------------------
  // latest store to an index overwrites the line
  always_ff @(posedge clk_i) begin
    if (st_cached) begin
      line_q[st_req_i.addr.split.idx].tag  <= st_req_i.addr.split.tag;
      line_q[st_req_i.addr.split.idx].slot <= tail_idx_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_valid_q <= '0;
    end else if (flush_i) begin
      // flush drops every recorded store
      line_valid_q <= '0;
    end else if (st_cached) begin
      line_valid_q[st_req_i.addr.split.idx] <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // lookup
  // ----------------------------------------------------------
  assign ld_idx    = ld_req_i.addr.split.idx;
  assign cache_hit = line_valid_q[ld_idx] &
                     (line_q[ld_idx].tag == ld_req_i.addr.split.tag);

  // slot to read back from the store buffer
  assign sb_idx_o  = line_q[ld_idx].slot;

  // slot must still hold this exact store
  // it may have been popped or reused since it was recorded
  assign st_hit    = sb_entry_i.valid &
                     (sb_entry_i.addr.raw == ld_req_i.addr.raw) &
                     (sb_entry_i.width == ld_req_i.width);

  assign fwd_valid = fwd_cfg_i.enable & ld_req_i.valid & cache_hit & st_hit;

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign fwd_valid_o = fwd_valid;
  assign fwd_value_o = sb_entry_i.value;
  // counted by the config block
  assign fwd_hit_o   = fwd_valid;

  // enable from the config block gates every forward
  a_fwd_needs_en : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fwd_valid_o |-> fwd_cfg_i.enable
  ) else $error("forward while forwarding disabled");

endmodule

/* src/stfwd_top.sv */
// ----------------------------------------------------------
// store-to-load forwarding top level
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "stfwd_config.svh"

module stfwd_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // store push and drain
  input  logic                   push_i,
  input  stfwd_pkg::st_req_t     st_req_i,
  output logic                   full_o,
  input  logic                   pop_i,
  output stfwd_pkg::sb_entry_t   drain_o,
  input  logic                   flush_i,
  // load lookup
  input  stfwd_pkg::ld_req_t     ld_req_i,
  output logic                   fwd_valid_o,
  output logic [`STFWD_XLEN-1:0] fwd_value_o,
  // config port
  input  logic                   cfg_we_i,
  input  logic [1:0]             cfg_addr_i,
  input  logic [`STFWD_XLEN-1:0] cfg_wdata_i,
  output logic [`STFWD_XLEN-1:0] cfg_rdata_o
);

  import stfwd_pkg::*;

  // ----------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------
  fwd_cfg_t                fwd_cfg;
  logic                    fwd_hit;
  logic                    push_ok;
  logic [`STFWD_IDX_W-1:0] tail_idx;
  logic [`STFWD_IDX_W-1:0] sb_idx;
  sb_entry_t               rd_entry;

  // config registers and hit counter
  fwd_cfg_regs u_cfg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .fwd_hit_i   (fwd_hit),
    .fwd_cfg_o   (fwd_cfg)
  );

  // speculative stores
  store_buffer u_sb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .push_i     (push_i),
    .st_req_i   (st_req_i),
    .push_ok_o  (push_ok),
    .tail_idx_o (tail_idx),
    .full_o     (full_o),
    .pop_i      (pop_i),
    .drain_o    (drain_o),
    .rd_idx_i   (sb_idx),
    .rd_entry_o (rd_entry)
  );

  // forwarding lookup
  l0_fwd_cache u_l0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .fwd_cfg_i   (fwd_cfg),
    .push_ok_i   (push_ok),
    .st_req_i    (st_req_i),
    .tail_idx_i  (tail_idx),
    .ld_req_i    (ld_req_i),
    .sb_idx_o    (sb_idx),
    .sb_entry_i  (rd_entry),
    .fwd_valid_o (fwd_valid_o),
    .fwd_value_o (fwd_value_o),
    .fwd_hit_o   (fwd_hit)
  );

endmodule

/* testbench/tb_stfwd.sv */
// ----------------------------------------------------------
// testbench for the store-to-load forwarding top level
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "stfwd_config.svh"

module tb_stfwd;

  import stfwd_pkg::*;

  localparam int PERIOD = 40;
  // reset, directed cycles, random cycles and a margin
  localparam int TIMEOUT_NS = (4 + 120 + 300 + 50) * PERIOD;
  // small address pool so loads often hit
  // 0x40 falls outside the reset mask
  localparam logic [31:0] POOL [8] = '{32'h1000, 32'h1001, 32'h2000, 32'h2001,
                                       32'h1005, 32'h2005, 32'h0040, 32'h1007};

  logic                   clk_i, rst_n_i, push_i, pop_i, flush_i, cfg_we_i;
  logic                   full_o, fwd_valid_o;
  logic [1:0]             cfg_addr_i;
  logic [`STFWD_XLEN-1:0] cfg_wdata_i, cfg_rdata_o, fwd_value_o;
  st_req_t                st_req_i;
  ld_req_t                ld_req_i;
  sb_entry_t              drain_o;

  // ----------------------------------------------------------
  // reference model state
  // ----------------------------------------------------------
  typedef struct packed {
    logic [31:0] seq;
    logic [31:0] addr;
    ldst_width_t width;
    logic [31:0] value;
  } model_entry_t;

  // buffer mirror with the oldest store first
  model_entry_t sb_q [$];
  // latest recorded store per index
  logic [7:0]   rec_valid;
  logic [31:0]  rec_addr [8];
  logic [31:0]  rec_seq [8];
  logic         mdl_en;
  logic [31:0]  mdl_mask, mdl_hits, seq_ctr, lcg_state;
  int           err_cnt, tests_run, tests_failed;

  stfwd_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD/2) clk_i = ~clk_i;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected {valid, value} of a load
  function automatic logic [32:0] ref_forward(input ld_req_t ld);
    logic [`STFWD_IDX_W-1:0] i;
    logic [32:0]             res;
    i = ld.addr.split.idx;
    res = '0;
    if (mdl_en && ld.valid && rec_valid[i] && (rec_addr[i] == ld.addr.raw)) begin
      // recorded store must still be buffered with the same width
      foreach (sb_q[k]) begin
        if ((sb_q[k].seq == rec_seq[i]) && (sb_q[k].width == ld.width)) begin
          res = {1'b1, sb_q[k].value};
        end
      end
    end
    return res;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // ----------------------------------------------------------
  // comparison just before each rising edge
  // ----------------------------------------------------------
  initial begin
    logic [32:0]  exp_fwd;
    logic         push_ok;
    model_entry_t ent;
    wait (rst_n_i);
    forever begin
      @(negedge clk_i);
      #(PERIOD/2 - 2);
      exp_fwd = ref_forward(ld_req_i);
      assert (fwd_valid_o == exp_fwd[32] && (!exp_fwd[32] || fwd_value_o == exp_fwd[31:0]))
        else flag_mismatch($sformatf("load %h: fwd %0b/%h, model %0b/%h", ld_req_i.addr.raw,
                                     fwd_valid_o, fwd_value_o, exp_fwd[32], exp_fwd[31:0]));
      assert (full_o == (sb_q.size() == `STFWD_SB_DEPTH))
        else flag_mismatch($sformatf("full flag %0b with %0d stores", full_o, sb_q.size()));
      assert (drain_o.valid == (sb_q.size() != 0) && (!drain_o.valid ||
              {drain_o.addr.raw, drain_o.width, drain_o.value} ==
              {sb_q[0].addr, sb_q[0].width, sb_q[0].value}))
        else flag_mismatch("drain output differs from the oldest model store");
      // advance the model past the edge
      // a push while full is dropped
      push_ok = push_i && (sb_q.size() < `STFWD_SB_DEPTH);
      if (flush_i) begin
        sb_q.delete();
        rec_valid = '0;
      end else begin
        if (pop_i && (sb_q.size() != 0)) begin
          sb_q.delete(0);
        end
        if (push_ok) begin
          ent = {seq_ctr, st_req_i.addr.raw, st_req_i.width, st_req_i.value};
          sb_q.push_back(ent);
          // recorded only with an address bit inside the mask
          if ((st_req_i.addr.raw & mdl_mask) != '0) begin
            rec_valid[st_req_i.addr.split.idx] = 1'b1;
            rec_addr[st_req_i.addr.split.idx] = st_req_i.addr.raw;
            rec_seq[st_req_i.addr.split.idx] = seq_ctr;
          end
          seq_ctr++;
        end
      end
      // a clear of the counter beats a hit
      if (cfg_we_i && (cfg_addr_i == `STFWD_REG_HITS)) begin
        mdl_hits = '0;
      end else if (exp_fwd[32] && (mdl_hits != '1)) begin
        mdl_hits++;
      end
      if (cfg_we_i && (cfg_addr_i == `STFWD_REG_CTRL)) begin
        mdl_en = cfg_wdata_i[0];
      end
      if (cfg_we_i && (cfg_addr_i == `STFWD_REG_MASK)) begin
        mdl_mask = cfg_wdata_i;
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus tasks driven from the falling edge
  // ----------------------------------------------------------
  task automatic next_cycle();
    @(negedge clk_i);
    push_i = 1'b0;
    pop_i = 1'b0;
    flush_i = 1'b0;
    cfg_we_i = 1'b0;
    ld_req_i.valid = 1'b0;
  endtask

  task automatic store(input logic [31:0] a, input ldst_width_t w, input logic [31:0] v);
    next_cycle();
    push_i = 1'b1;
    st_req_i = {a, w, v};
  endtask

  // load with the outcome the forwarding rules give
  task automatic probe(input logic [31:0] a, input ldst_width_t w, input logic ev,
                       input logic [31:0] ev_val);
    next_cycle();
    ld_req_i = {1'b1, a, w};
    #(PERIOD/4);
    assert (fwd_valid_o == ev && (!ev || fwd_value_o == ev_val))
      else flag_mismatch($sformatf("load %h: fwd %0b/%h, expected %0b/%h", a, fwd_valid_o,
                                   fwd_value_o, ev, ev_val));
  endtask

  task automatic cfg_write(input logic [1:0] a, input logic [31:0] d);
    next_cycle();
    cfg_we_i = 1'b1;
    cfg_addr_i = a;
    cfg_wdata_i = d;
  endtask

  task automatic cfg_check(input logic [1:0] a, input logic [31:0] d);
    next_cycle();
    cfg_addr_i = a;
    #(PERIOD/4);
    assert (cfg_rdata_o == d)
      else flag_mismatch($sformatf("register %0d read %h, expected %h", a, cfg_rdata_o, d));
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    int          e;
    logic [31:0] r;
    rst_n_i = 1'b0;
    {push_i, pop_i, flush_i, cfg_we_i} = '0;
    st_req_i = '0;
    ld_req_i = '0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    rec_valid = '0;
    mdl_en = 1'b1;
    mdl_mask = `STFWD_MASK_RST;
    mdl_hits = '0;
    seq_ctr = '0;
    lcg_state = 32'h3ac9;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    e = err_cnt;
    store(32'h1000, LS_WORD, 32'h1111_1111);
    probe(32'h1000, LS_WORD, 1'b1, 32'h1111_1111);
    probe(32'h1008, LS_WORD, 1'b0, '0);
    close_test("basic forwarding", e);

    // 0x2010 shares index 0 with 0x1010
    e = err_cnt;
    store(32'h1010, LS_WORD, 32'hAAAA_0001);
    store(32'h1010, LS_WORD, 32'hAAAA_0002);
    probe(32'h1010, LS_WORD, 1'b1, 32'hAAAA_0002);
    store(32'h2010, LS_WORD, 32'hBBBB_0003);
    probe(32'h1010, LS_WORD, 1'b0, '0);
    probe(32'h2010, LS_WORD, 1'b1, 32'hBBBB_0003);
    close_test("latest store wins", e);

    e = err_cnt;
    probe(32'h2010, LS_HALF, 1'b0, '0);
    store(32'h0040, LS_WORD, 32'hCCCC_0004);
    probe(32'h0040, LS_WORD, 1'b0, '0);
    cfg_write(`STFWD_REG_CTRL, 32'h0);
    probe(32'h2010, LS_WORD, 1'b0, '0);
    cfg_write(`STFWD_REG_CTRL, 32'h1);
    probe(32'h2010, LS_WORD, 1'b1, 32'hBBBB_0003);
    close_test("width and mask rules", e);

    // fill from empty so the ninth push is dropped
    e = err_cnt;
    next_cycle();
    flush_i = 1'b1;
    for (int k = 0; k < 8; k++) begin
      store(32'h3000 + k, LS_WORD, 32'hD000_0000 + k);
    end
    next_cycle();
    assert (full_o) else flag_mismatch("buffer not full after eight pushes");
    store(32'h3008, LS_WORD, 32'hDEAD_0008);
    probe(32'h3000, LS_WORD, 1'b1, 32'hD000_0000);
    for (int k = 0; k < 8; k++) begin
      next_cycle();
      assert (drain_o.valid && (drain_o.value == 32'hD000_0000 + k))
        else flag_mismatch($sformatf("drain %0d gave %0b/%h", k, drain_o.valid, drain_o.value));
      pop_i = 1'b1;
    end
    probe(32'h3000, LS_WORD, 1'b0, '0);
    assert (!drain_o.valid) else flag_mismatch("dropped store showed up in the drain");
    close_test("drain and full", e);

    e = err_cnt;
    store(32'h1000, LS_WORD, 32'hEEEE_0001);
    store(32'h1004, LS_HALF, 32'hEEEE_0002);
    probe(32'h1004, LS_HALF, 1'b1, 32'hEEEE_0002);
    // six more stores on indices 1 to 3 fill the buffer
    for (int k = 0; k < 6; k++) begin
      store(32'h5001 + 32'h100 * k + k % 3, LS_WORD, 32'hF000_0000 + k);
    end
    next_cycle();
    assert (full_o) else flag_mismatch("buffer not full before the flush");
    flush_i = 1'b1;
    probe(32'h1000, LS_WORD, 1'b0, '0);
    probe(32'h1004, LS_HALF, 1'b0, '0);
    assert (!full_o && !drain_o.valid) else flag_mismatch("full or drain valid after flush");
    close_test("flush", e);

    e = err_cnt;
    cfg_write(`STFWD_REG_MASK, 32'h0F0F_F0F0);
    cfg_check(`STFWD_REG_MASK, 32'h0F0F_F0F0);
    cfg_write(`STFWD_REG_CTRL, 32'hFFFF_FFFE);
    cfg_check(`STFWD_REG_CTRL, 32'h0);
    cfg_write(`STFWD_REG_CTRL, 32'hFFFF_FFFF);
    cfg_check(`STFWD_REG_CTRL, 32'h1);
    cfg_write(`STFWD_REG_MASK, `STFWD_MASK_RST);
    cfg_write(`STFWD_REG_HITS, 32'h0);
    cfg_check(`STFWD_REG_HITS, 32'h0);
    // random traffic over the pool
    // the low LCG bits stay unused
    for (int n = 0; n < 300; n++) begin
      r = rand_next();
      if (r[30:28] < 3'd3) begin
        store(POOL[r[27:25]], ldst_width_t'(r[24:23] == 2'b11 ? 2'b10 : r[24:23]), rand_next());
      end else begin
        next_cycle();
      end
      pop_i = (r[22:21] == 2'b00) && (sb_q.size() != 0);
      flush_i = (r[13:6] == 8'h00);
      ld_req_i = {r[20] | r[19], POOL[r[18:16]],
                  ldst_width_t'(r[15:14] == 2'b11 ? 2'b00 : r[15:14])};
    end
    // idle cycle so the last hit reaches the counter
    next_cycle();
    cfg_check(`STFWD_REG_HITS, mdl_hits);
    assert (mdl_hits != 0) else begin
      $display("random traffic gave no forwards, so the hit count proves nothing");
      err_cnt++;
    end
    close_test("config readback and hit count", e);

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
    if ((err_cnt == 0) && (tests_failed == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/stfwd_pkg.sv
src/fwd_cfg_regs.sv
src/store_buffer.sv
src/l0_fwd_cache.sv
src/stfwd_top.sv
testbench/tb_stfwd.sv

/* Bender.yml */
package:
  name: stfwd

sources:
  - include_dirs:
      - src
    files:
      - src/stfwd_pkg.sv
      - src/fwd_cfg_regs.sv
      - src/store_buffer.sv
      - src/l0_fwd_cache.sv
      - src/stfwd_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_stfwd.sv
